// ==== design/lane_pkg.sv ====
package lane_pkg;

  //////////////////////////////
  // Datapath widths
  //////////////////////////////

  // Element width of the lane datapath
  localparam int unsigned ElenW = 32;
  // Half element, used by the split multiplier
  localparam int unsigned ElenHalfW = ElenW / 2;

  //////////////////////////////
  // Register file geometry
  //////////////////////////////

  localparam int unsigned NrVRegs = 8;
  localparam int unsigned VRegIdxW = 3;

  //////////////////////////////
  // Instruction fields
  //////////////////////////////

  // Instruction tag carried to the result stream
  localparam int unsigned IdW = 4;
  localparam int unsigned OpW = 3;

  // ALU operations
  localparam logic [OpW-1:0] OpAdd = 3'd0;
  localparam logic [OpW-1:0] OpSub = 3'd1;
  localparam logic [OpW-1:0] OpAnd = 3'd2;
  localparam logic [OpW-1:0] OpOr = 3'd3;
  localparam logic [OpW-1:0] OpXor = 3'd4;

  // Multiplier operation
  localparam logic [OpW-1:0] OpMul = 3'd5;

  // Encodings 6 and 7 are reserved

endpackage

// ==== design/vector_regfile.sv ====
`timescale 1ns/10ps

module vector_regfile import lane_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Combinational read ports
  input  logic [VRegIdxW-1:0] rd_idx_a_i,
  input  logic [VRegIdxW-1:0] rd_idx_b_i,
  output logic [ElenW-1:0]    rd_data_a_o,
  output logic [ElenW-1:0]    rd_data_b_o,
  // Load write port
  input  logic                ld_we_i,
  input  logic [VRegIdxW-1:0] ld_idx_i,
  input  logic [ElenW-1:0]    ld_data_i,
  // Writeback write port
  input  logic                wb_we_i,
  input  logic [VRegIdxW-1:0] wb_idx_i,
  input  logic [ElenW-1:0]    wb_data_i
);

  logic [ElenW-1:0] regs_q [NrVRegs];

  assign rd_data_a_o = regs_q[rd_idx_a_i];
  assign rd_data_b_o = regs_q[rd_idx_b_i];

  //////////////////////////////
  // Write ports
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NrVRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NrVRegs; i++) begin
        // Load takes priority on a same-index collision
        if (ld_we_i && (ld_idx_i == VRegIdxW'(i))) begin
          regs_q[i] <= ld_data_i;
        end else if (wb_we_i && (wb_idx_i == VRegIdxW'(i))) begin
          regs_q[i] <= wb_data_i;
        end
      end
    end
  end

endmodule

// ==== design/lane_alu.sv ====
`timescale 1ns/10ps

module lane_alu import lane_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Dispatch side
  input  logic                op_valid_i,
  output logic                op_ready_o,
  input  logic [OpW-1:0]      op_i,
  input  logic [ElenW-1:0]    a_i,
  input  logic [ElenW-1:0]    b_i,
  input  logic [VRegIdxW-1:0] vd_i,
  input  logic [IdW-1:0]      id_i,
  // Result side
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output logic [VRegIdxW-1:0] res_vd_o,
  output logic [IdW-1:0]      res_id_o,
  output logic [ElenW-1:0]    res_data_o
);

  logic [ElenW-1:0] result;
  logic             valid_q;

  // All arithmetic wraps modulo 2^ElenW
  always_comb begin
    case (op_i)
      OpAdd:   result = a_i + b_i;
      OpSub:   result = a_i - b_i;
      OpAnd:   result = a_i & b_i;
      OpOr:    result = a_i | b_i;
      OpXor:   result = a_i ^ b_i;
      default: result = '0;
    endcase
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  assign op_ready_o = ~valid_q | res_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (op_ready_o) begin
      valid_q <= op_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_valid_i && op_ready_o) begin
      res_vd_o   <= vd_i;
      res_id_o   <= id_i;
      res_data_o <= result;
    end
  end

  assign res_valid_o = valid_q;

endmodule

// ==== design/lane_mul.sv ====
`timescale 1ns/10ps

module lane_mul import lane_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Dispatch side
  input  logic                op_valid_i,
  output logic                op_ready_o,
  input  logic [ElenW-1:0]    a_i,
  input  logic [ElenW-1:0]    b_i,
  input  logic [VRegIdxW-1:0] vd_i,
  input  logic [IdW-1:0]      id_i,
  // Result side
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output logic [VRegIdxW-1:0] res_vd_o,
  output logic [IdW-1:0]      res_id_o,
  output logic [ElenW-1:0]    res_data_o
);

  logic                 advance;
  logic                 s1_valid_q;
  logic [VRegIdxW-1:0]  s1_vd_q;
  logic [IdW-1:0]       s1_id_q;
  logic [ElenW-1:0]     s1_plo_q;
  logic [ElenHalfW-1:0] s1_phi_q;
  logic                 s2_valid_q;

  // The whole pipe moves together, stalled only by a held output
  assign advance    = ~s2_valid_q | res_ready_i;
  assign op_ready_o = advance;

  //////////////////////////////
  // Valid bits
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= op_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  //////////////////////////////
  // Partial products
  //////////////////////////////

  // Low word of a*b = a_lo*b + (a_hi*b_lo << half), a_hi*b_hi drops out
  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_vd_q  <= vd_i;
      s1_id_q  <= id_i;
      s1_plo_q <= ElenW'(a_i[ElenHalfW-1:0] * b_i);
      s1_phi_q <= ElenHalfW'(a_i[ElenW-1:ElenHalfW] * b_i[ElenHalfW-1:0]);
      res_vd_o   <= s1_vd_q;
      res_id_o   <= s1_id_q;
      res_data_o <= s1_plo_q + {s1_phi_q, {ElenHalfW{1'b0}}};
    end
  end

  assign res_valid_o = s2_valid_q;

endmodule

// ==== design/writeback_arbiter.sv ====
`timescale 1ns/10ps

module writeback_arbiter import lane_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // ALU result
  input  logic                alu_valid_i,
  output logic                alu_ready_o,
  input  logic [VRegIdxW-1:0] alu_vd_i,
  input  logic [IdW-1:0]      alu_id_i,
  input  logic [ElenW-1:0]    alu_data_i,
  // Multiplier result
  input  logic                mul_valid_i,
  output logic                mul_ready_o,
  input  logic [VRegIdxW-1:0] mul_vd_i,
  input  logic [IdW-1:0]      mul_id_i,
  input  logic [ElenW-1:0]    mul_data_i,
  // Register file writeback and busy release
  output logic                wb_we_o,
  output logic [VRegIdxW-1:0] wb_idx_o,
  output logic [ElenW-1:0]    wb_data_o,
  output logic [NrVRegs-1:0]  wb_clr_o,
  // Result stream
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output logic [VRegIdxW-1:0] res_vd_o,
  output logic [IdW-1:0]      res_id_o,
  output logic [ElenW-1:0]    res_data_o
);

  logic             out_free;
  logic             mul_gnt;
  logic             alu_gnt;
  logic [IdW-1:0]   sel_id;

  //////////////////////////////
  // Fixed priority grant
  //////////////////////////////

  // Output slot is empty or leaving this cycle
  assign out_free = ~res_valid_o | res_ready_i;
  assign mul_gnt  = mul_valid_i & out_free;
  assign alu_gnt  = alu_valid_i & out_free & ~mul_valid_i;

  assign mul_ready_o = mul_gnt;
  assign alu_ready_o = alu_gnt;

  assign wb_we_o   = mul_gnt | alu_gnt;
  assign wb_idx_o  = mul_gnt ? mul_vd_i : alu_vd_i;
  assign wb_data_o = mul_gnt ? mul_data_i : alu_data_i;
  assign sel_id    = mul_gnt ? mul_id_i : alu_id_i;

  // One-hot release of the written register
  assign wb_clr_o = wb_we_o ? (NrVRegs'(1) << wb_idx_o) : '0;

  //////////////////////////////
  // Result output register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
    end else if (out_free) begin
      res_valid_o <= wb_we_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_we_o) begin
      res_vd_o   <= wb_idx_o;
      res_id_o   <= sel_id;
      res_data_o <= wb_data_o;
    end
  end

endmodule

// ==== design/lane_sequencer.sv ====
`timescale 1ns/10ps

module lane_sequencer import lane_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Request stream
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic [OpW-1:0]      req_op_i,
  input  logic [VRegIdxW-1:0] req_vd_i,
  input  logic [VRegIdxW-1:0] req_vs1_i,
  input  logic [VRegIdxW-1:0] req_vs2_i,
  input  logic [IdW-1:0]      req_id_i,
  // Register file read ports
  output logic [VRegIdxW-1:0] rd_idx_a_o,
  output logic [VRegIdxW-1:0] rd_idx_b_o,
  input  logic [ElenW-1:0]    rd_data_a_i,
  input  logic [ElenW-1:0]    rd_data_b_i,
  // ALU dispatch
  output logic                alu_valid_o,
  input  logic                alu_ready_i,
  output logic [OpW-1:0]      alu_op_o,
  output logic [ElenW-1:0]    alu_a_o,
  output logic [ElenW-1:0]    alu_b_o,
  output logic [VRegIdxW-1:0] alu_vd_o,
  output logic [IdW-1:0]      alu_id_o,
  // Multiplier dispatch
  output logic                mul_valid_o,
  input  logic                mul_ready_i,
  output logic [ElenW-1:0]    mul_a_o,
  output logic [ElenW-1:0]    mul_b_o,
  output logic [VRegIdxW-1:0] mul_vd_o,
  output logic [IdW-1:0]      mul_id_o,
  // Busy release from writeback
  input  logic [NrVRegs-1:0]  wb_clr_i
);

  //////////////////////////////
  // Hazard check
  //////////////////////////////

  logic [NrVRegs-1:0] busy_q;
  logic [NrVRegs-1:0] busy_set;
  logic               active_q;
  logic               is_mul;
  logic               unit_ready;
  logic               hazard;
  logic               dispatch;

  assign is_mul     = (req_op_i == OpMul);
  assign unit_ready = is_mul ? mul_ready_i : alu_ready_i;

  // Destination and both sources must have no pending writer
  assign hazard = busy_q[req_vd_i] | busy_q[req_vs1_i] | busy_q[req_vs2_i];

  // Held off for the first cycle out of reset
  assign req_ready_o = active_q & ~hazard & unit_ready;
  assign dispatch    = req_valid_i & req_ready_o;

  //////////////////////////////
  // Operand read and dispatch
  //////////////////////////////

  assign rd_idx_a_o = req_vs1_i;
  assign rd_idx_b_o = req_vs2_i;

  assign alu_valid_o = dispatch & ~is_mul;
  assign alu_op_o    = req_op_i;
  assign alu_a_o     = rd_data_a_i;
  assign alu_b_o     = rd_data_b_i;
  assign alu_vd_o    = req_vd_i;
  assign alu_id_o    = req_id_i;

  assign mul_valid_o = dispatch & is_mul;
  assign mul_a_o     = rd_data_a_i;
  assign mul_b_o     = rd_data_b_i;
  assign mul_vd_o    = req_vd_i;
  assign mul_id_o    = req_id_i;

  //////////////////////////////
  // Busy scoreboard
  //////////////////////////////

  assign busy_set = dispatch ? (NrVRegs'(1) << req_vd_i) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= '0;
      active_q <= 1'b0;
    end else begin
      // A set never hits a bit being cleared, the vd was idle
      busy_q   <= (busy_q & ~wb_clr_i) | busy_set;
      active_q <= 1'b1;
    end
  end

endmodule

// ==== design/lane_top.sv ====
`timescale 1ns/10ps

module lane_top import lane_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Load port
  input  logic                ld_valid_i,
  input  logic [VRegIdxW-1:0] ld_idx_i,
  input  logic [ElenW-1:0]    ld_data_i,
  // Request stream
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic [OpW-1:0]      req_op_i,
  input  logic [VRegIdxW-1:0] req_vd_i,
  input  logic [VRegIdxW-1:0] req_vs1_i,
  input  logic [VRegIdxW-1:0] req_vs2_i,
  input  logic [IdW-1:0]      req_id_i,
  // Result stream
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output logic [IdW-1:0]      res_id_o,
  output logic [VRegIdxW-1:0] res_vd_o,
  output logic [ElenW-1:0]    res_data_o
);

  //////////////////////////////
  // Sequencer and register file
  //////////////////////////////

  logic [VRegIdxW-1:0] rd_idx_a;
  logic [VRegIdxW-1:0] rd_idx_b;
  logic [ElenW-1:0]    rd_data_a;
  logic [ElenW-1:0]    rd_data_b;

  logic                wb_we;
  logic [VRegIdxW-1:0] wb_idx;
  logic [ElenW-1:0]    wb_data;
  logic [NrVRegs-1:0]  wb_clr;

  // Dispatch to the ALU
  logic                alu_valid;
  logic                alu_ready;
  logic [OpW-1:0]      alu_op;
  logic [ElenW-1:0]    alu_a;
  logic [ElenW-1:0]    alu_b;
  logic [VRegIdxW-1:0] alu_vd;
  logic [IdW-1:0]      alu_id;

  // Dispatch to the multiplier
  logic                mul_valid;
  logic                mul_ready;
  logic [ElenW-1:0]    mul_a;
  logic [ElenW-1:0]    mul_b;
  logic [VRegIdxW-1:0] mul_vd;
  logic [IdW-1:0]      mul_id;

  lane_sequencer i_lane_sequencer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_vd_i    (req_vd_i),
    .req_vs1_i   (req_vs1_i),
    .req_vs2_i   (req_vs2_i),
    .req_id_i    (req_id_i),
    .rd_idx_a_o  (rd_idx_a),
    .rd_idx_b_o  (rd_idx_b),
    .rd_data_a_i (rd_data_a),
    .rd_data_b_i (rd_data_b),
    .alu_valid_o (alu_valid),
    .alu_ready_i (alu_ready),
    .alu_op_o    (alu_op),
    .alu_a_o     (alu_a),
    .alu_b_o     (alu_b),
    .alu_vd_o    (alu_vd),
    .alu_id_o    (alu_id),
    .mul_valid_o (mul_valid),
    .mul_ready_i (mul_ready),
    .mul_a_o     (mul_a),
    .mul_b_o     (mul_b),
    .mul_vd_o    (mul_vd),
    .mul_id_o    (mul_id),
    .wb_clr_i    (wb_clr)
  );

  vector_regfile i_vrf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_idx_a_i  (rd_idx_a),
    .rd_idx_b_i  (rd_idx_b),
    .rd_data_a_o (rd_data_a),
    .rd_data_b_o (rd_data_b),
    .ld_we_i     (ld_valid_i),
    .ld_idx_i    (ld_idx_i),
    .ld_data_i   (ld_data_i),
    .wb_we_i     (wb_we),
    .wb_idx_i    (wb_idx),
    .wb_data_i   (wb_data)
  );

  //////////////////////////////
  // Functional units
  //////////////////////////////

  logic                alu_res_valid;
  logic                alu_res_ready;
  logic [VRegIdxW-1:0] alu_res_vd;
  logic [IdW-1:0]      alu_res_id;
  logic [ElenW-1:0]    alu_res_data;

  logic                mul_res_valid;
  logic                mul_res_ready;
  logic [VRegIdxW-1:0] mul_res_vd;
  logic [IdW-1:0]      mul_res_id;
  logic [ElenW-1:0]    mul_res_data;

  lane_alu i_lane_alu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op_valid_i  (alu_valid),
    .op_ready_o  (alu_ready),
    .op_i        (alu_op),
    .a_i         (alu_a),
    .b_i         (alu_b),
    .vd_i        (alu_vd),
    .id_i        (alu_id),
    .res_valid_o (alu_res_valid),
    .res_ready_i (alu_res_ready),
    .res_vd_o    (alu_res_vd),
    .res_id_o    (alu_res_id),
    .res_data_o  (alu_res_data)
  );

  lane_mul i_lane_mul (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op_valid_i  (mul_valid),
    .op_ready_o  (mul_ready),
    .a_i         (mul_a),
    .b_i         (mul_b),
    .vd_i        (mul_vd),
    .id_i        (mul_id),
    .res_valid_o (mul_res_valid),
    .res_ready_i (mul_res_ready),
    .res_vd_o    (mul_res_vd),
    .res_id_o    (mul_res_id),
    .res_data_o  (mul_res_data)
  );

  //////////////////////////////
  // Writeback
  //////////////////////////////

  writeback_arbiter i_wb_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .alu_valid_i (alu_res_valid),
    .alu_ready_o (alu_res_ready),
    .alu_vd_i    (alu_res_vd),
    .alu_id_i    (alu_res_id),
    .alu_data_i  (alu_res_data),
    .mul_valid_i (mul_res_valid),
    .mul_ready_o (mul_res_ready),
    .mul_vd_i    (mul_res_vd),
    .mul_id_i    (mul_res_id),
    .mul_data_i  (mul_res_data),
    .wb_we_o     (wb_we),
    .wb_idx_o    (wb_idx),
    .wb_data_o   (wb_data),
    .wb_clr_o    (wb_clr),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_vd_o    (res_vd_o),
    .res_id_o    (res_id_o),
    .res_data_o  (res_data_o)
  );

endmodule

// ==== verif/lane_tb_assertions.sv ====
`timescale 1ns/10ps

module lane_tb_assertions import lane_pkg::*; (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                res_valid_i,
  input logic                res_ready_i,
  input logic [IdW-1:0]      res_id_i,
  input logic [VRegIdxW-1:0] res_vd_i,
  input logic [ElenW-1:0]    res_data_i
);

  // Failures seen so far
  int unsigned fail_count = 0;

  //////////////////////////////
  // Result stream
  //////////////////////////////

  // A stalled result holds until it is taken
  property p_res_stable;
    @(posedge clk_i) disable iff (!rst_ni)
      (res_valid_i && !res_ready_i) |=>
        (res_valid_i && $stable(res_id_i) && $stable(res_vd_i) && $stable(res_data_i));
  endproperty

  property p_res_idle_in_reset;
    @(posedge clk_i) !rst_ni |-> !res_valid_i;
  endproperty

  property p_res_data_known;
    @(posedge clk_i) disable iff (!rst_ni)
      res_valid_i |-> !$isunknown(res_data_i);
  endproperty

  a_res_stable: assert property (p_res_stable)
    else begin
      $error("result stream changed while stalled");
      fail_count++;
    end

  a_res_idle_in_reset: assert property (p_res_idle_in_reset)
    else begin
      $error("res_valid_o high during reset");
      fail_count++;
    end

  a_res_data_known: assert property (p_res_data_known)
    else begin
      $error("res_data_o has unknown bits while valid");
      fail_count++;
    end

endmodule

// ==== verif/lane_tb.sv ====
`timescale 1ns/10ps

module lane_tb import lane_pkg::*; ();

  localparam int unsigned Seed          = 50739;
  localparam int unsigned ClkHalf       = 50;
  localparam int unsigned NumAlu        = 20;
  localparam int unsigned NumMul        = 20;
  localparam int unsigned NumChain      = 20;
  localparam int unsigned NumStress     = 40;
  localparam int unsigned NumInstr      = NumAlu + NumMul + NumChain + NumStress;
  localparam int unsigned TimeoutCycles = NumInstr * 20 + 200;
  localparam int unsigned NumIds        = 1 << IdW;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                ld_valid;
  logic [VRegIdxW-1:0] ld_idx;
  logic [ElenW-1:0]    ld_data;
  logic                req_valid;
  logic                req_ready;
  logic [OpW-1:0]      req_op;
  logic [VRegIdxW-1:0] req_vd;
  logic [VRegIdxW-1:0] req_vs1;
  logic [VRegIdxW-1:0] req_vs2;
  logic [IdW-1:0]      req_id;
  logic                res_valid;
  logic                res_ready;
  logic [IdW-1:0]      res_id;
  logic [VRegIdxW-1:0] res_vd;
  logic [ElenW-1:0]    res_data;

  // Reference model state
  logic [ElenW-1:0]    model_regs [NrVRegs];
  logic [ElenW-1:0]    exp_data [NumIds];
  logic [VRegIdxW-1:0] exp_vd [NumIds];
  bit                  pending [NumIds];
  logic [IdW-1:0]      next_id;
  bit                  bp_on;
  int unsigned         outstanding;
  int unsigned         retired_count;
  int unsigned         test_count;
  int unsigned         check_count;
  int unsigned         error_count;
  int unsigned         test_checks0;
  int unsigned         test_errors0;

  always #(ClkHalf) clk = ~clk;

  lane_top lane_top_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .ld_valid_i  (ld_valid),
    .ld_idx_i    (ld_idx),
    .ld_data_i   (ld_data),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_op_i    (req_op),
    .req_vd_i    (req_vd),
    .req_vs1_i   (req_vs1),
    .req_vs2_i   (req_vs2),
    .req_id_i    (req_id),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .res_id_o    (res_id),
    .res_vd_o    (res_vd),
    .res_data_o  (res_data)
  );

  bind lane_top lane_tb_assertions i_assertions (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .res_valid_i (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_id_i    (res_id_o),
    .res_vd_i    (res_vd_o),
    .res_data_i  (res_data_o)
  );

  //////////////////////////////
  // Model and stimulus helpers
  //////////////////////////////

  function automatic logic [ElenW-1:0] expected_result(input logic [OpW-1:0]   op,
                                                       input logic [ElenW-1:0] a,
                                                       input logic [ElenW-1:0] b);
    logic [2*ElenW-1:0] product;
    product = {{ElenW{1'b0}}, a} * {{ElenW{1'b0}}, b};
    case (op)
      OpAdd:   return a + b;
      OpSub:   return a - b;
      OpAnd:   return a & b;
      OpOr:    return a | b;
      OpXor:   return a ^ b;
      OpMul:   return product[ElenW-1:0];
      default: return '0;
    endcase
  endfunction

  function automatic logic [OpW-1:0] pick_alu_op();
    case ($urandom_range(0, 4))
      0:       return OpAdd;
      1:       return OpSub;
      2:       return OpAnd;
      3:       return OpOr;
      default: return OpXor;
    endcase
  endfunction

  // Roughly one in three goes to the multiplier
  function automatic logic [OpW-1:0] pick_any_op();
    if ($urandom_range(0, 2) == 0) begin
      return OpMul;
    end else begin
      return pick_alu_op();
    end
  endfunction

  function automatic logic [VRegIdxW-1:0] rand_idx();
    return VRegIdxW'($urandom_range(0, NrVRegs - 1));
  endfunction

  task automatic compare_data(input logic [ElenW-1:0] got, input logic [ElenW-1:0] exp,
                              input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic verify_index(input logic [VRegIdxW-1:0] got,
                              input logic [VRegIdxW-1:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic expect_flag(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic load_reg(input logic [VRegIdxW-1:0] idx, input logic [ElenW-1:0] data);
    @(posedge clk);
    ld_valid <= 1'b1;
    ld_idx   <= idx;
    ld_data  <= data;
    model_regs[idx] = data;
    @(posedge clk);
    ld_valid <= 1'b0;
  endtask

  task automatic load_all();
    for (int i = 0; i < NrVRegs; i++) begin
      load_reg(VRegIdxW'(i), $urandom());
    end
  endtask

  task automatic send_req(input logic [OpW-1:0] op, input logic [VRegIdxW-1:0] vd,
                          input logic [VRegIdxW-1:0] vs1, input logic [VRegIdxW-1:0] vs2);
    logic [IdW-1:0] id;
    id = next_id;
    while (pending[id]) @(negedge clk);
    @(posedge clk);
    req_valid <= 1'b1;
    req_op    <= op;
    req_vd    <= vd;
    req_vs1   <= vs1;
    req_vs2   <= vs2;
    req_id    <= id;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    // Sources are final once the request is accepted on the coming edge
    exp_data[id] = expected_result(op, model_regs[vs1], model_regs[vs2]);
    exp_vd[id]   = vd;
    pending[id]  = 1'b1;
    outstanding++;
    model_regs[vd] = exp_data[id];
    next_id = id + 1'b1;
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic wait_idle();
    while (outstanding != 0) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("Test %-12s done: %0d checks, %0d errors", name,
             check_count - test_checks0, error_count - test_errors0);
    test_checks0 = check_count;
    test_errors0 = error_count;
  endtask

  //////////////////////////////
  // Result monitor
  //////////////////////////////

  always @(negedge clk) begin
    if (rst_n && res_valid && res_ready) begin
      retired_count++;
      if (!pending[res_id]) begin
        error_count++;
        $display("Result with id %0d at %0t matches no pending instruction", res_id, $time);
      end else begin
        compare_data(res_data, exp_data[res_id], $sformatf("id %0d data", res_id));
        verify_index(res_vd, exp_vd[res_id], $sformatf("id %0d vd", res_id));
        pending[res_id] = 1'b0;
        outstanding--;
      end
    end
  end

  always @(posedge clk) begin
    if (bp_on) begin
      res_ready <= ($urandom_range(0, 1) == 1);
    end else begin
      res_ready <= 1'b1;
    end
  end

  initial begin
    #(TimeoutCycles * ClkHalf * 2);
    $display("Run timed out after %0d cycles with %0d results missing",
             TimeoutCycles, outstanding);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    bit                  ready_seen;
    logic [VRegIdxW-1:0] chain_vd;
    logic [VRegIdxW-1:0] prev_vd;
    int unsigned         stress_base;
    void'($urandom(Seed));
    rst_n     = 1'b0;
    ld_valid  = 1'b0;
    ld_idx    = '0;
    ld_data   = '0;
    req_valid = 1'b0;
    req_op    = OpAdd;
    req_vd    = '0;
    req_vs1   = '0;
    req_vs2   = '0;
    req_id    = '0;
    res_ready = 1'b1;
    bp_on     = 1'b0;
    next_id   = '0;
    for (int i = 0; i < NumIds; i++) begin
      pending[i] = 1'b0;
    end
    for (int i = 0; i < NrVRegs; i++) begin
      model_regs[i] = '0;
    end

    // Reset behavior
    repeat (4) @(negedge clk);
    expect_flag(res_valid, 1'b0, "res_valid_o in reset");
    expect_flag(req_ready, 1'b0, "req_ready_o in reset");
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    ready_seen = 1'b0;
    for (int i = 0; i < 10 && !ready_seen; i++) begin
      @(negedge clk);
      ready_seen = req_ready;
    end
    if (!ready_seen) begin
      error_count++;
      $display("req_ready_o did not rise within 10 cycles of leaving reset");
    end
    finish_test("reset");

    load_all();
    repeat (NumAlu) send_req(pick_alu_op(), rand_idx(), rand_idx(), rand_idx());
    wait_idle();
    finish_test("alu_random");

    load_all();
    repeat (NumMul) send_req(OpMul, rand_idx(), rand_idx(), rand_idx());
    wait_idle();
    finish_test("mul_random");

    // Each source is the previous destination
    load_all();
    prev_vd = rand_idx();
    repeat (NumChain) begin
      chain_vd = rand_idx();
      send_req(pick_any_op(), chain_vd, prev_vd, rand_idx());
      prev_vd = chain_vd;
    end
    wait_idle();
    finish_test("chain");

    load_all();
    @(negedge clk);
    bp_on = 1'b1;
    stress_base = retired_count;
    repeat (NumStress) send_req(pick_any_op(), rand_idx(), rand_idx(), rand_idx());
    wait_idle();
    @(negedge clk);
    bp_on = 1'b0;
    if (retired_count - stress_base != NumStress) begin
      error_count++;
      $display("Back-pressure run returned %0d results for %0d requests",
               retired_count - stress_base, NumStress);
    end
    finish_test("backpressure");

    if (lane_top_i.i_assertions.fail_count != 0) begin
      error_count += lane_top_i.i_assertions.fail_count;
      $display("%0d assertion failures seen", lane_top_i.i_assertions.fail_count);
    end
    $display("Summary: %0d tests, %0d checks, %0d errors",
             test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
design/lane_pkg.sv
design/vector_regfile.sv
design/lane_alu.sv
design/lane_mul.sv
design/writeback_arbiter.sv
design/lane_sequencer.sv
design/lane_top.sv
verif/lane_tb_assertions.sv
verif/lane_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := lane_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
RUN_ARGS  := +verilator+error+limit+100
PASS_MSG  := TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
